// File: common/bus_ctrl_pkg.sv
package bus_ctrl_pkg;

    localparam int MASTER_COUNT     = 2;
    localparam int SLAVE_COUNT      = 3;
    localparam int DATA_WIDTH       = 16;
    localparam int SLAVE_DEPTHS [SLAVE_COUNT] = '{4096, 4096, 2048};
    localparam int ADDR_WIDTH       = $clog2(SLAVE_DEPTHS[0]);  // masters reach the largest slave
    localparam int SLAVE_ID_WIDTH   = 2;
    localparam int BANK_DEPTH       = 16;                       // words per master
    localparam int BANK_ADDR_WIDTH  = $clog2(BANK_DEPTH);
    localparam int CONFIG_CLK_COUNT = 2;                        // cycles per configuration step
    localparam int DEBOUNCE_CYCLES  = 4;

    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // command bundle towards one master
    typedef struct packed {
        logic                      burst;
        logic                      rd_wr;
        logic                      ext_write;
        logic [SLAVE_ID_WIDTH-1:0] slave_id;   // 1..3, 0 means slave 1
        addr_t                     address;
        data_t                     data;
        logic                      start;
    } master_cmd_t;

    typedef enum logic [3:0] {
        st_slave_sel, st_rd_wr_sel, st_ext_write_sel,
        st_ext_write_m1, st_ext_write_m1_2, st_ext_write_m2,
        st_addr_sel_m1, st_addr_sel_m2, st_count_sel_m1, st_count_sel_m2,
        st_config, st_comm_ready, st_communicating, st_comm_done
    } setup_state_t;

    // board phase, configuration is reported as selecting
    typedef enum logic [1:0] {
        stat_selecting,
        stat_comm_ready,
        stat_communicating,
        stat_comm_done
    } ctrl_status_t;

endpackage

// File: control/config_sequencer.sv
`timescale 1ns/1ps

module config_sequencer import bus_ctrl_pkg::*; (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic                       config_go,
    input  addr_t                      first_addr [MASTER_COUNT],
    input  logic [MASTER_COUNT-1:0]    ext_write,
    input  logic [BANK_ADDR_WIDTH-1:0] wr_count [MASTER_COUNT],
    input  data_t                      bank_rd_data,
    output logic                       bank_rd_master,
    output logic [BANK_ADDR_WIDTH-1:0] bank_rd_index,
    output logic [MASTER_COUNT-1:0]    seq_start,
    output addr_t                      seq_address [MASTER_COUNT],
    output data_t                      seq_data [MASTER_COUNT],
    output logic                       config_done
);

    typedef enum logic [1:0] {
        cfg_start,
        cfg_middle,
        cfg_last,
        cfg_done       // idle between runs
    } cfg_state_t;

    cfg_state_t                          cfg_state;
    logic                                cur_master;
    logic [$clog2(CONFIG_CLK_COUNT)-1:0] clk_cnt;
    logic [BANK_ADDR_WIDTH-1:0]          word_idx;
    logic [BANK_ADDR_WIDTH-1:0]          word_total;
    data_t                               word_out;
    data_t                               data_hold [MASTER_COUNT];
    logic                                busy;
    logic                                step_end;
    logic                                master_end;

    assign busy       = (cfg_state != cfg_done);
    assign step_end   = (clk_cnt == $bits(clk_cnt)'(CONFIG_CLK_COUNT - 1));
    assign word_total = ext_write[cur_master] ? wr_count[cur_master] : '0;
    assign word_out   = (word_total != '0) ? bank_rd_data : '0;   // unwritten slots stay hidden

    // zero or one word is a single step, otherwise the last word ends the master
    assign master_end = step_end &&
                        ((cfg_state == cfg_start && word_total <= BANK_ADDR_WIDTH'(1)) ||
                         cfg_state == cfg_last);

    assign bank_rd_master = cur_master;
    assign bank_rd_index  = word_idx;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            cfg_state   <= cfg_done;
            cur_master  <= 1'b0;
            clk_cnt     <= '0;
            word_idx    <= '0;
            config_done <= 1'b0;
        end else begin
            config_done <= 1'b0;
            if (config_go) begin
                cfg_state  <= cfg_start;
                cur_master <= 1'b0;
                clk_cnt    <= '0;
                word_idx   <= '0;
            end else if (busy) begin
                clk_cnt <= step_end ? '0 : clk_cnt + 1'b1;
                if (master_end) begin
                    word_idx <= '0;
                    if (cur_master == 1'(MASTER_COUNT - 1)) begin
                        cfg_state   <= cfg_done;
                        config_done <= 1'b1;
                    end else begin
                        cur_master <= cur_master + 1'b1;
                        cfg_state  <= cfg_start;
                    end
                end else if (step_end) begin
                    word_idx <= word_idx + 1'b1;
                    if (word_idx + BANK_ADDR_WIDTH'(2) == word_total) begin
                        cfg_state <= cfg_last;     // next word is the final one
                    end else begin
                        cfg_state <= cfg_middle;
                    end
                end
            end
        end
    end

    // keeps each master's last word on its data field once it is finished
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            data_hold <= '{default: '0};
        end else if (busy) begin
            data_hold[cur_master] <= word_out;
        end
    end

    always_comb begin
        for (int m = 0; m < MASTER_COUNT; m++) begin
            seq_start[m]   = cur_master == 1'(m) && clk_cnt == '0 &&
                             (cfg_state == cfg_start || cfg_state == cfg_last);
            seq_address[m] = first_addr[m];
            seq_data[m]    = (busy && cur_master == 1'(m)) ? word_out : data_hold[m];
        end
    end

endmodule

// File: control/setup_fsm.sv
`timescale 1ns/1ps

module setup_fsm import bus_ctrl_pkg::*; (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    step_press,
    input  logic                    next_press,
    input  logic [15:0]             sw,
    input  logic [MASTER_COUNT-1:0] done_com,
    input  logic                    config_done,
    input  logic [MASTER_COUNT-1:0] seq_start,
    input  addr_t                   seq_address [MASTER_COUNT],
    input  data_t                   seq_data [MASTER_COUNT],
    output logic                    bank_wr_en,
    output logic                    bank_master,
    output logic                    bank_advance,
    output logic                    bank_clear,
    output data_t                   bank_data,
    output logic                    config_go,
    output addr_t                   first_addr [MASTER_COUNT],
    output logic [MASTER_COUNT-1:0] ext_write,
    output master_cmd_t             cmd [MASTER_COUNT],
    output ctrl_status_t            status
);

    setup_state_t              state;
    logic [SLAVE_ID_WIDTH-1:0] slave_id [MASTER_COUNT];
    logic [MASTER_COUNT-1:0]   rd_wr;
    logic [MASTER_COUNT-1:0]   burst;
    logic [MASTER_COUNT-1:0]   start_q;
    addr_t                     last_addr [MASTER_COUNT];
    addr_t                     address_q [MASTER_COUNT];
    addr_t                     sw_addr;
    logic                      in_ext_write;
    logic                      in_config;

    // first + count, held inside the selected slave
    function automatic addr_t clamp_last(addr_t first, addr_t count,
                                         logic [SLAVE_ID_WIDTH-1:0] id);
        int depth;
        int sum;
        depth = (id == '0) ? SLAVE_DEPTHS[0] : SLAVE_DEPTHS[id - 1'b1];
        sum   = int'(first) + int'(count);
        if (sum > depth - 1) begin
            return ADDR_WIDTH'(depth - 1);
        end
        return ADDR_WIDTH'(sum);
    endfunction

    assign sw_addr = sw[ADDR_WIDTH-1:0];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state      <= st_slave_sel;
            slave_id   <= '{default: '0};
            rd_wr      <= '0;
            ext_write  <= '0;
            burst      <= '0;
            start_q    <= '0;
            first_addr <= '{default: '0};
            last_addr  <= '{default: '0};
            address_q  <= '{default: '0};
        end else begin
            case (state)
                st_slave_sel: begin
                    if (step_press) begin
                        for (int m = 0; m < MASTER_COUNT; m++) begin
                            slave_id[m] <= sw[2*m+1 -: 2];     // two switches per master
                        end
                        state <= st_rd_wr_sel;
                    end
                end
                st_rd_wr_sel: begin
                    if (step_press) begin
                        rd_wr <= sw[MASTER_COUNT-1:0];
                        state <= st_ext_write_sel;
                    end
                end
                st_ext_write_sel: begin
                    if (step_press) begin
                        ext_write <= sw[MASTER_COUNT-1:0];
                        case (sw[1:0])
                            2'b01:   state <= st_ext_write_m1;
                            2'b10:   state <= st_ext_write_m2;
                            2'b11:   state <= st_ext_write_m1_2;
                            default: state <= st_addr_sel_m1;
                        endcase
                    end
                end
                st_ext_write_m1_2: begin
                    if (step_press) begin
                        state <= st_ext_write_m2;
                    end
                end
                st_ext_write_m1, st_ext_write_m2: begin
                    if (step_press) begin
                        state <= st_addr_sel_m1;
                    end
                end
                st_addr_sel_m1: begin
                    if (step_press) begin
                        first_addr[0] <= sw_addr;
                        state         <= st_addr_sel_m2;
                    end
                end
                st_addr_sel_m2: begin
                    if (step_press) begin
                        first_addr[1] <= sw_addr;
                        state         <= st_count_sel_m1;
                    end
                end
                st_count_sel_m1: begin
                    if (step_press) begin
                        burst[0]     <= (sw_addr != '0);
                        last_addr[0] <= clamp_last(first_addr[0], sw_addr, slave_id[0]);
                        state        <= st_count_sel_m2;
                    end
                end
                st_count_sel_m2: begin
                    if (step_press) begin
                        burst[1]     <= (sw_addr != '0);
                        last_addr[1] <= clamp_last(first_addr[1], sw_addr, slave_id[1]);
                        state        <= st_config;
                    end
                end
                st_config: begin
                    if (config_done) begin
                        address_q <= last_addr;    // burst end the masters run to
                        state     <= st_comm_ready;
                    end
                end
                st_comm_ready: begin
                    if (step_press) begin
                        start_q <= '1;
                        state   <= st_communicating;
                    end
                end
                st_communicating: begin
                    start_q <= '0;
                    if (&done_com) begin
                        state <= st_comm_done;
                    end
                end
                st_comm_done: begin
                    // read-back, both masters look at the same address
                    if (next_press) begin
                        for (int m = 0; m < MASTER_COUNT; m++) begin
                            address_q[m] <= sw_addr;
                        end
                    end
                end
                default: state <= st_slave_sel;
            endcase
        end
    end

    assign in_ext_write = (state == st_ext_write_m1) || (state == st_ext_write_m1_2) ||
                          (state == st_ext_write_m2);
    assign in_config    = (state == st_config);
    assign bank_wr_en   = in_ext_write;
    assign bank_master  = (state == st_ext_write_m2);
    assign bank_advance = in_ext_write && next_press;    // word accepted
    assign bank_clear   = in_ext_write && step_press;
    assign bank_data    = sw[DATA_WIDTH-1:0];
    assign config_go    = (state == st_count_sel_m2) && step_press;

    always_comb begin
        case (state)
            st_comm_ready:    status = stat_comm_ready;
            st_communicating: status = stat_communicating;
            st_comm_done:     status = stat_comm_done;
            default:          status = stat_selecting;
        endcase
    end

    // sequencer drives start and address while configuring
    always_comb begin
        for (int m = 0; m < MASTER_COUNT; m++) begin
            cmd[m].burst     = burst[m];
            cmd[m].rd_wr     = rd_wr[m];
            cmd[m].ext_write = ext_write[m];
            cmd[m].slave_id  = slave_id[m];
            cmd[m].address   = in_config ? seq_address[m] : address_q[m];
            cmd[m].data      = seq_data[m];
            cmd[m].start     = in_config ? seq_start[m] : start_q[m];
        end
    end

endmodule

// File: control/write_bank.sv
`timescale 1ns/1ps

module write_bank import bus_ctrl_pkg::*; (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic                       wr_en,
    input  logic                       wr_master,
    input  logic                       wr_advance,
    input  logic                       wr_clear,
    input  data_t                      wr_data,
    input  logic                       rd_master,
    input  logic [BANK_ADDR_WIDTH-1:0] rd_index,
    output data_t                      rd_data,
    output logic [BANK_ADDR_WIDTH-1:0] wr_count [MASTER_COUNT]
);

    data_t                      bank_mem [MASTER_COUNT][BANK_DEPTH];
    logic [BANK_ADDR_WIDTH-1:0] wr_ptr;

    // the slot under the pointer follows the switches until it is counted
    always_ff @(posedge clk) begin
        if (wr_en) begin
            bank_mem[wr_master][wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wr_ptr   <= '0;
            wr_count <= '{default: '0};
        end else if (wr_clear) begin
            wr_ptr <= '0;            // next master starts at word 0
        end else if (wr_advance &&
                     wr_count[wr_master] != BANK_ADDR_WIDTH'(BANK_DEPTH - 1)) begin
            wr_ptr              <= wr_ptr + 1'b1;
            wr_count[wr_master] <= wr_count[wr_master] + 1'b1;   // saturates, count never wraps
        end
    end

    assign rd_data = bank_mem[rd_master][rd_index];

endmodule

// File: files.f
common/bus_ctrl_pkg.sv
hdl/key_debouncer.sv
control/write_bank.sv
control/config_sequencer.sv
control/setup_fsm.sv
hdl/bus_ctrl_top.sv
tb/tb_bus_ctrl_top.sv

// File: hdl/bus_ctrl_top.sv
`timescale 1ns/1ps

module bus_ctrl_top import bus_ctrl_pkg::*; (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic [1:0]              keys,       // [0] step, [1] next address
    input  logic [15:0]             sw,
    output master_cmd_t             cmd [MASTER_COUNT],
    input  logic [MASTER_COUNT-1:0] done_com,
    input  data_t                   data_out [MASTER_COUNT],
    output ctrl_status_t            status,
    output data_t                   read_data [MASTER_COUNT]
);

    logic                       step_press;
    logic                       next_press;
    logic                       bank_wr_en;
    logic                       bank_master;
    logic                       bank_advance;
    logic                       bank_clear;
    data_t                      bank_data;
    logic                       bank_rd_master;
    logic [BANK_ADDR_WIDTH-1:0] bank_rd_index;
    data_t                      bank_rd_data;
    logic [BANK_ADDR_WIDTH-1:0] wr_count [MASTER_COUNT];
    logic                       config_go;
    logic                       config_done;
    addr_t                      first_addr [MASTER_COUNT];
    logic [MASTER_COUNT-1:0]    ext_write;
    logic [MASTER_COUNT-1:0]    seq_start;
    addr_t                      seq_address [MASTER_COUNT];
    data_t                      seq_data [MASTER_COUNT];

    key_debouncer u_step_key (.clk, .rstN, .key_raw(keys[0]), .press(step_press));
    key_debouncer u_next_key (.clk, .rstN, .key_raw(keys[1]), .press(next_press));

    setup_fsm u_setup (
        .clk, .rstN, .step_press, .next_press, .sw, .done_com,
        .config_done, .seq_start, .seq_address, .seq_data,
        .bank_wr_en, .bank_master, .bank_advance, .bank_clear, .bank_data,
        .config_go, .first_addr, .ext_write, .cmd, .status
    );

    write_bank u_bank (
        .clk, .rstN,
        .wr_en      (bank_wr_en),
        .wr_master  (bank_master),
        .wr_advance (bank_advance),
        .wr_clear   (bank_clear),
        .wr_data    (bank_data),
        .rd_master  (bank_rd_master),
        .rd_index   (bank_rd_index),
        .rd_data    (bank_rd_data),
        .wr_count
    );

    config_sequencer u_seq (
        .clk, .rstN, .config_go, .first_addr, .ext_write, .wr_count,
        .bank_rd_data, .bank_rd_master, .bank_rd_index,
        .seq_start, .seq_address, .seq_data, .config_done
    );

    // masters' read ports sampled every cycle
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            read_data <= '{default: '0};
        end else begin
            read_data <= data_out;
        end
    end

endmodule

// File: hdl/key_debouncer.sv
`timescale 1ns/1ps

module key_debouncer import bus_ctrl_pkg::*; (
    input  logic clk,
    input  logic rstN,
    input  logic key_raw,     // active low
    output logic press
);

    logic [1:0]                         key_sync;
    logic [$clog2(DEBOUNCE_CYCLES)-1:0] stable_cnt;
    logic                               key_level;
    logic                               key_level_d;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            key_sync    <= 2'b11;
            stable_cnt  <= '0;
            key_level   <= 1'b1;     // released
            key_level_d <= 1'b1;
            press       <= 1'b0;
        end else begin
            key_sync    <= {key_sync[0], key_raw};
            key_level_d <= key_level;
            press       <= key_level_d && !key_level;   // one pulse per falling edge
            if (key_sync[1] == key_level) begin
                stable_cnt <= '0;    // bounce restarts the wait
            end else if (stable_cnt == $bits(stable_cnt)'(DEBOUNCE_CYCLES - 1)) begin
                stable_cnt <= '0;
                key_level  <= key_sync[1];
            end else begin
                stable_cnt <= stable_cnt + 1'b1;
            end
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# compile and run the bus control testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wall -Wno-fatal \
    -f files.f \
    --top-module tb_bus_ctrl_top \
    -o sim_bus_ctrl

./obj_dir/sim_bus_ctrl | tee sim.log

if grep -q "Simulation FAILED" sim.log; then
    echo "run failed, see sim.log"
    exit 1
fi
echo "run passed"

// File: tb/golden_vectors.txt
// one scenario per block of 22 words, hex
// slave_sw rdwr_sw ext_sw | n0 w0[4] | n1 w1[4] | first0 first1 | cnt0 cnt1
// const0 const1 | readback_sw | last0 last1
0007 0001 0003
0003 A11A B22B C33C 0000
0002 1D1D 2E2E 0000 0000
0700 0123 0200 0050
5A5A 0F0F 0234 07FF 0173
// second scenario, only master 2 writes, master 2 has no burst
0008 0002 0002
0000 0000 0000 0000 0000
0004 1111 2222 3333 4444
0F00 0010 0200 0000
FFFF 1234 0ABC 0FFF 0010

// File: tb/tb_bus_ctrl_top.sv
`timescale 1ns/1ps

module tb_bus_ctrl_top import bus_ctrl_pkg::*; ();

    localparam int SCEN_COUNT = 2;
    localparam int SCEN_WORDS = 22;
    localparam int WATCHDOG_CYCLES = SCEN_COUNT * 2000;
    localparam int G_SLAVE = 0;
    localparam int G_RDWR  = 1;
    localparam int G_EXT   = 2;
    localparam int G_N0    = 3;
    localparam int G_W0    = 4;
    localparam int G_N1    = 8;
    localparam int G_W1    = 9;
    localparam int G_FIRST = 13;
    localparam int G_CNT   = 15;
    localparam int G_CONST = 17;
    localparam int G_RB    = 19;
    localparam int G_LAST  = 20;

    logic                    clk;
    logic                    rstN;
    logic [1:0]              keys;
    logic [15:0]             sw;
    master_cmd_t             cmd [MASTER_COUNT];
    logic [MASTER_COUNT-1:0] done_com;
    data_t                   data_out [MASTER_COUNT];
    ctrl_status_t            status;
    data_t                   read_data [MASTER_COUNT];

    logic [15:0] golden [0:SCEN_COUNT*SCEN_WORDS-1];
    int          cur;                         // scenario under test
    logic        in_cfg;
    logic        was_comm;                    // status was communicating one cycle ago
    logic        done_seen;                   // every done_com high one cycle ago
    data_t       last_data [MASTER_COUNT];
    data_t       seen [MASTER_COUNT][BANK_DEPTH];
    int          seen_n [MASTER_COUNT];
    int          cfg_starts [MASTER_COUNT];
    int          start_cycles [MASTER_COUNT];
    int          done_wait [MASTER_COUNT];
    int          err_cmd;
    int          err_status;
    int          err_data;
    int          err_other;

    bus_ctrl_top dut0 (.clk, .rstN, .keys, .sw, .cmd, .done_com, .data_out, .status, .read_data);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [15:0] gv(int off);
        return golden[cur*SCEN_WORDS + off];
    endfunction

    // command a master should hold once configuration is over
    function automatic master_cmd_t expected_cmd(int m);
        master_cmd_t e;
        logic [15:0] slv;
        logic [15:0] cnt;
        logic [15:0] rdwr;
        logic [15:0] ext;
        int          n;
        int          wbase;
        slv   = gv(G_SLAVE);
        cnt   = gv(G_CNT + m);
        rdwr  = gv(G_RDWR);
        ext   = gv(G_EXT);
        n     = int'(gv(m == 0 ? G_N0 : G_N1));
        wbase = (m == 0) ? G_W0 : G_W1;
        e           = '0;
        e.burst     = (cnt[ADDR_WIDTH-1:0] != '0);
        e.rd_wr     = rdwr[m];
        e.ext_write = ext[m];
        e.slave_id  = slv[2*m +: 2];
        e.address   = addr_t'(gv(G_LAST + m));
        e.data      = (e.ext_write && n > 0) ? gv(wbase + n - 1) : '0;
        return e;
    endfunction

    task automatic check_cmd(input master_cmd_t act, input master_cmd_t exp, input string name);
        if (act !== exp) begin
            err_cmd++;
            $display("[ERROR] %s: got %h expected %h", name, act, exp);
        end
    endtask

    task automatic check_status(input ctrl_status_t act, input ctrl_status_t exp);
        if (act !== exp) begin
            err_status++;
            $display("[ERROR] status: got %h expected %h", act, exp);
        end
    endtask

    task automatic check_data(input data_t act, input data_t exp, input string name);
        if (act !== exp) begin
            err_data++;
            $display("[ERROR] %s: got %h expected %h", name, act, exp);
        end
    endtask

    // random hold length still gives a single step
    task automatic press_key(input int idx, input logic [15:0] sw_val);
        int hold;
        hold = 8 + int'($urandom % 13);
        @(posedge clk);
        sw        <= sw_val;
        keys[idx] <= 1'b0;
        repeat (hold) @(posedge clk);
        keys[idx] <= 1'b1;
        repeat (12) @(posedge clk);
    endtask

    task automatic wait_status(input ctrl_status_t st);
        while (status != st) @(negedge clk);
    endtask

    task automatic bank_words(input int m);
        int n;
        n = int'(gv(m == 0 ? G_N0 : G_N1));
        for (int i = 0; i < n; i++) begin
            press_key(1, gv((m == 0 ? G_W0 : G_W1) + i));
        end
        press_key(0, 16'h0000);     // on to the next write state
    endtask

    // master models drive data_out from the address and raise done some cycles after start
    always @(posedge clk) begin
        for (int m = 0; m < MASTER_COUNT; m++) begin
            data_out[m] <= data_t'(cmd[m].address) ^ gv(G_CONST + m);
            if (cmd[m].start && status == stat_communicating) begin
                done_wait[m] = 2 + int'($urandom % 10);
            end else if (done_wait[m] > 0) begin
                done_wait[m] = done_wait[m] - 1;
                if (done_wait[m] == 0) done_com[m] <= 1'b1;
            end
        end
    end

    always @(negedge clk) begin
        master_cmd_t e;
        if (rstN) begin
            for (int m = 0; m < MASTER_COUNT; m++) begin
                if (in_cfg && status == stat_selecting) begin
                    if (cmd[m].data !== last_data[m] && seen_n[m] < BANK_DEPTH) begin
                        seen[m][seen_n[m]] = cmd[m].data;
                        seen_n[m]++;
                    end
                    last_data[m] = cmd[m].data;
                    if (cmd[m].start) begin
                        cfg_starts[m]++;
                        e         = expected_cmd(m);
                        e.address = addr_t'(gv(G_FIRST + m));
                        e.data    = cmd[m].data;
                        e.start   = 1'b1;
                        check_cmd(cmd[m], e, $sformatf("cmd[%0d] config start", m));
                    end
                end
                if (cmd[m].start && status != stat_selecting) start_cycles[m]++;
            end
            if (status != stat_selecting && cmd[0].start != cmd[1].start) begin
                err_other++;
                $display("start bits of the two masters were not raised together");
            end
            if (was_comm) begin
                check_status(status, done_seen ? stat_comm_done : stat_communicating);
            end
            was_comm  = (status == stat_communicating);
            done_seen = &done_com;
        end
    end

    task automatic run_scenario();
        logic [15:0] ext;
        int          n;
        ext = gv(G_EXT);
        @(posedge clk);
        rstN     <= 1'b0;
        keys     <= 2'b11;
        sw       <= '0;
        done_com <= '0;
        in_cfg    = 1'b0;
        was_comm  = 1'b0;
        done_seen = 1'b0;
        for (int m = 0; m < MASTER_COUNT; m++) begin
            last_data[m]    = '0;
            seen_n[m]       = 0;
            cfg_starts[m]   = 0;
            start_cycles[m] = 0;
            done_wait[m]    = 0;
        end
        repeat (5) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        check_status(status, stat_selecting);
        for (int m = 0; m < MASTER_COUNT; m++) begin
            check_cmd(cmd[m], '0, $sformatf("cmd[%0d] after reset", m));
            check_data(read_data[m], '0, $sformatf("read_data[%0d] after reset", m));
        end

        press_key(0, gv(G_SLAVE));
        press_key(0, gv(G_RDWR));
        press_key(0, ext);
        if (ext[0]) bank_words(0);
        if (ext[1]) bank_words(1);
        press_key(0, gv(G_FIRST));
        press_key(0, gv(G_FIRST + 1));
        press_key(0, gv(G_CNT));
        in_cfg = 1'b1;
        press_key(0, gv(G_CNT + 1));
        wait_status(stat_comm_ready);
        in_cfg = 1'b0;

        for (int m = 0; m < MASTER_COUNT; m++) begin
            check_cmd(cmd[m], expected_cmd(m), $sformatf("cmd[%0d] comm_ready", m));
            n = ext[m] ? int'(gv(m == 0 ? G_N0 : G_N1)) : 0;
            if (cfg_starts[m] != ((n > 1) ? 2 : 1)) begin
                err_other++;
                $display("master %0d got %0d start pulses in configuration instead of %0d",
                         m, cfg_starts[m], (n > 1) ? 2 : 1);
            end
            if (seen_n[m] != n) begin
                err_other++;
                $display("master %0d saw %0d config words instead of %0d", m, seen_n[m], n);
            end else begin
                for (int i = 0; i < n; i++) begin
                    check_data(seen[m][i], gv((m == 0 ? G_W0 : G_W1) + i),
                               $sformatf("cmd[%0d].data word %0d", m, i));
                end
            end
        end

        press_key(0, 16'h0000);
        wait_status(stat_comm_done);
        press_key(1, gv(G_RB));
        @(negedge clk);
        for (int m = 0; m < MASTER_COUNT; m++) begin
            check_data(read_data[m], data_t'(gv(G_RB) & 16'h0FFF) ^ gv(G_CONST + m),
                       $sformatf("read_data[%0d]", m));
            if (start_cycles[m] != 1) begin
                err_other++;
                $display("master %0d start was high for %0d cycles instead of one",
                         m, start_cycles[m]);
            end
        end
    endtask

    initial begin
        rstN      = 1'b0;
        keys      = 2'b11;
        sw        = '0;
        done_com  = '0;
        data_out  = '{default: '0};
        cur       = 0;
        in_cfg    = 1'b0;
        was_comm  = 1'b0;
        done_seen = 1'b0;
        err_cmd   = 0;
        err_status = 0;
        err_data  = 0;
        err_other = 0;
        void'($urandom(88373));
        $readmemh("tb/golden_vectors.txt", golden);
        for (int s = 0; s < SCEN_COUNT; s++) begin
            cur = s;
            run_scenario();
        end
        $display("errors: cmd %0d status %0d data %0d other %0d",
                 err_cmd, err_status, err_data, err_other);
        if (err_cmd + err_status + err_data + err_other == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // watchdog sized from the scenario count
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout, the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("errors: cmd %0d status %0d data %0d other %0d",
                 err_cmd, err_status, err_data, err_other + 1);
        $display("Simulation FAILED");
        $finish;
    end

endmodule
